// ==== sim.f ====
ifu_pkg.sv
fetch_ctrl.sv
icache.sv
next_pc.sv
inst_fifo.sv
ifu.sv
ifu_properties.sv
tb_ifu.sv

// ==== Makefile ====
# Verilator build and run of the IFU testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build tb_ifu with Verilator, run it, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --assert --top-module tb_ifu -f sim.f -o sim_ifu
	./obj_dir/sim_ifu +verilator+error+limit+100 > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "Result: PASSED" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_ifu.sv ====
// IFU testbench with Wishbone memory model, recovery and back-pressure stimulus
`timescale 1ns/1ps

module tb_ifu import ifu_pkg::*; ();
    localparam int    NUM_XFERS      = 1500;
    localparam int    TIMEOUT_CYCLES = NUM_XFERS * 20;  // Refill of about 20 cycles each
    localparam addr_t RESET_PC       = '0;

    logic   clk;
    logic   rst_n;
    logic   recovery_valid;
    addr_t  recovery_pc;
    logic   instr_ready;
    instr_t wb_dat_i;
    logic   wb_ack;
    logic   instr_valid;
    instr_t instr_data;
    addr_t  instr_pc;
    logic   instr_is_br;
    logic   instr_pred_taken;
    addr_t  instr_pred_target;
    logic   wb_cyc;
    logic   wb_stb;
    addr_t  wb_adr;

    addr_t exp_pc      = RESET_PC;  // Next PC dispatch should see
    int    xfer_count  = 0;
    int    cycle_count = 0;
    int    gap_left    = 150;       // Cycles to next recovery
    int    stall_left  = 0;         // Forced ready-low stretch
    int    ack_wait    = -1;        // -1 while no beat pending

    ifu u_dut (
        .clk(clk), .rst_n(rst_n), .recovery_valid(recovery_valid), .recovery_pc(recovery_pc),
        .instr_ready(instr_ready), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
        .instr_valid(instr_valid), .instr_data(instr_data), .instr_pc(instr_pc),
        .instr_is_br(instr_is_br), .instr_pred_taken(instr_pred_taken),
        .instr_pred_target(instr_pred_target), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
        .wb_adr(wb_adr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Word kind, 0 plain, 1 jump, 2 conditional branch
    function automatic int kind_of(input int w);
        if (w == 1023 || w % 13 == 0) return 1;   // Last word jumps back into region
        if (w % 7 == 0) return 2;
        return 0;
    endfunction

    // Intended target word of a jump or branch
    function automatic int target_of(input int w);
        if (kind_of(w) == 1) return (w * 37 + 11) % 1024;
        if ((w / 7) % 2 == 1) return w - 1 - (w % 6);  // Backward
        return w + 2 + (w % 9);                         // Forward
    endfunction

    function automatic logic taken_of(input int w);
        return kind_of(w) == 1 || (kind_of(w) == 2 && target_of(w) < w);
    endfunction

    // Memory contents over words 0 to 1023
    function automatic instr_t instr_at(input addr_t a);
        int          w;
        int          off;
        logic [20:0] j;
        logic [12:0] b;
        w   = int'(a[11:2]);
        off = (target_of(w) - w) * 4;
        j   = 21'(off);
        b   = 13'(off);
        case (kind_of(w))
            1: return {j[20], j[10:1], j[11], j[19:12], 5'd1, OPC_JAL};
            2: return {b[12], b[10:5], 5'(w), 5'(w >> 5), 3'b000, b[4:1], b[11], OPC_BRANCH};
            default: return {12'(w * 3 + 1), 5'(w), 3'b000, 5'(w >> 5), 7'b001_0011};
        endcase
    endfunction

    function automatic addr_t next_of(input addr_t pc);
        int w;
        w = int'(pc[11:2]);
        if (taken_of(w)) return addr_t'(target_of(w) * 4);
        return pc + 4;
    endfunction

    task automatic fail_run();
        $display("Result: FAILED");
        $fatal(1, "Run stopped on the first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
            fail_run();
        end
    endtask

    // One accepted entry against the prediction rule
    task automatic check_xfer();
        int w;
        w = int'(instr_pc[11:2]);
        check_eq("instr_pc", instr_pc, exp_pc);
        check_eq("instr_data", instr_data, instr_at(instr_pc));
        check_eq("instr_is_br", 32'(instr_is_br), 32'(kind_of(w) != 0));
        check_eq("instr_pred_taken", 32'(instr_pred_taken), 32'(taken_of(w)));
        check_eq("instr_pred_target", instr_pred_target, next_of(instr_pc));
        exp_pc = next_of(instr_pc);
        xfer_count++;
    endtask

    // Inputs for the coming cycle, Wishbone slave included
    task automatic drive_cycle();
        if (stall_left > 0) begin
            instr_ready = 1'b0;
            stall_left--;
        end else begin
            instr_ready = ($urandom_range(99) < 70);
            if ($urandom_range(399) == 0) stall_left = 40;  // Long enough to fill the FIFO
        end
        recovery_valid = 1'b0;
        if (gap_left == 0) begin
            recovery_valid = 1'b1;
            recovery_pc    = {20'd0, 10'($urandom_range(1023)), 2'b00};
            gap_left       = $urandom_range(180, 120);
        end else begin
            gap_left--;
        end
        if (wb_ack) begin
            wb_ack = 1'b0;                                  // One-cycle ack
        end else if (wb_cyc && wb_stb) begin
            if (ack_wait < 0) ack_wait = $urandom_range(3);
            if (ack_wait == 0) begin
                wb_ack   = 1'b1;
                wb_dat_i = instr_at(wb_adr);
                ack_wait = -1;
            end else begin
                ack_wait--;
            end
        end
    endtask

    // Dispatch-side scoreboard
    always @(posedge clk) begin
        if (rst_n) begin
            if (recovery_valid) begin
                assert (!instr_valid) else begin
                    $display("An instruction was offered to dispatch in a recovery cycle");
                    fail_run();
                end
                exp_pc = recovery_pc;
            end else if (instr_valid && instr_ready) begin
                check_xfer();
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout with %0d of %0d instructions", xfer_count, NUM_XFERS);
            fail_run();
        end else if (u_dut.u_props.fail_count != 0) begin
            $display("A bound protocol assertion failed");
            fail_run();
        end
    end

    initial begin
        void'($urandom(32'h8478));
        rst_n          = 1'b0;
        recovery_valid = 1'b0;
        recovery_pc    = '0;
        instr_ready    = 1'b0;
        wb_dat_i       = '0;
        wb_ack         = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        while (xfer_count < NUM_XFERS) begin
            @(posedge clk);
            #1;
            drive_cycle();
        end
        if (u_dut.u_props.fail_count != 0) begin
            $display("A bound protocol assertion failed");
            fail_run();
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

// ==== ifu_properties.sv ====
// IFU protocol checker for Wishbone refill, reset values and dispatch-side stability
`timescale 1ns/1ps

module ifu_properties import ifu_pkg::*; #(
    parameter int LINE_WORDS = 4
) (
    input logic   clk,
    input logic   rst_n,
    input logic   recovery_valid,
    input logic   instr_valid,
    input logic   instr_ready,
    input instr_t instr_data,
    input addr_t  instr_pc,
    input logic   instr_is_br,
    input logic   instr_pred_taken,
    input addr_t  instr_pred_target,
    input logic   wb_cyc,
    input logic   wb_stb,
    input addr_t  wb_adr,
    input logic   wb_ack
);
    localparam int OFF_W = $clog2(LINE_WORDS);

    int unsigned                  fail_count = 0;  // Watched by the testbench
    logic [OFF_W-1:0]             beat_q;          // Expected word of the next beat
    logic [ADDR_WIDTH-OFF_W-3:0]  line_q;          // Line of the previous beat

    // Follow the refill beat by beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_q <= '0;
            line_q <= '0;
        end else if (wb_cyc && wb_ack) begin
            beat_q <= (beat_q == OFF_W'(LINE_WORDS - 1)) ? '0 : beat_q + 1'b1;
            line_q <= wb_adr[ADDR_WIDTH-1:OFF_W+2];
        end
    end

    // Strobe only inside a cycle
    assert property (@(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc)
        else begin fail_count++; $error("wb_stb high without wb_cyc"); end

    // Request held with a stable address until ack
    assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb && !wb_ack |=> wb_cyc && wb_stb && $stable(wb_adr))
        else begin fail_count++; $error("Wishbone request dropped or changed before ack"); end

    // Consecutive words of one line, word aligned
    assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb |-> wb_adr[1:0] == 2'b00 && wb_adr[OFF_W+1:2] == beat_q
            && (beat_q == '0 || wb_adr[ADDR_WIDTH-1:OFF_W+2] == line_q))
        else begin fail_count++; $error("Refill address out of line order"); end

    // Quiet first cycle out of reset
    assert property (@(posedge clk) $rose(rst_n) |-> !wb_cyc && !instr_valid)
        else begin fail_count++; $error("wb_cyc or instr_valid high after reset"); end

    // Offered entry holds until taken, recovery may withdraw it
    assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid && !instr_ready |=> (instr_valid || recovery_valid)
            && $stable({instr_data, instr_pc, instr_is_br, instr_pred_taken, instr_pred_target}))
        else begin fail_count++; $error("Dispatch outputs changed under back-pressure"); end

endmodule

bind ifu ifu_properties #(.LINE_WORDS(LINE_WORDS)) u_props (
    .clk(clk), .rst_n(rst_n), .recovery_valid(recovery_valid), .instr_valid(instr_valid),
    .instr_ready(instr_ready), .instr_data(instr_data), .instr_pc(instr_pc),
    .instr_is_br(instr_is_br), .instr_pred_taken(instr_pred_taken),
    .instr_pred_target(instr_pred_target), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
    .wb_adr(wb_adr), .wb_ack(wb_ack)
);

// ==== ifu.sv ====
// Instruction fetch unit top with PC register, control FSM, I-cache, predecoder and FIFO
`timescale 1ns/1ps

module ifu import ifu_pkg::*; #(
    parameter int    LINE_WORDS = 4,
    parameter int    NUM_SETS   = 16,
    parameter int    FIFO_DEPTH = 8,
    parameter addr_t RESET_PC   = '0
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   recovery_valid,
    input  addr_t  recovery_pc,
    input  logic   instr_ready,
    input  instr_t wb_dat_i,
    input  logic   wb_ack,
    output logic   instr_valid,
    output instr_t instr_data,
    output addr_t  instr_pc,
    output logic   instr_is_br,
    output logic   instr_pred_taken,
    output addr_t  instr_pred_target,
    output logic   wb_cyc,
    output logic   wb_stb,
    output addr_t  wb_adr
);
    localparam int OFF_W = $clog2(LINE_WORDS);

    addr_t            pc_q;
    addr_t            pred_pc;
    instr_t           rd_instr;
    logic             hit;
    logic             is_br;
    logic             pred_taken;
    logic             pc_hold;
    logic             pc_redirect;
    logic             fifo_push;
    logic             fifo_flush;
    logic             enq_ready;
    logic             fifo_valid;
    logic             fill_we;
    logic [OFF_W-1:0] fill_word;
    addr_t            fill_adr;

    // PC mux priority: recovery, hold, predicted
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else if (pc_redirect) begin
            pc_q <= recovery_pc;
        end else if (!pc_hold) begin
            pc_q <= pred_pc;
        end
    end

    fetch_ctrl #(.LINE_WORDS(LINE_WORDS)) u_ctrl (
        .clk(clk), .rst_n(rst_n), .hit(hit), .enq_ready(enq_ready),
        .recovery_valid(recovery_valid), .pc(pc_q), .wb_ack(wb_ack),
        .pc_hold(pc_hold), .pc_redirect(pc_redirect), .fifo_push(fifo_push),
        .fifo_flush(fifo_flush), .fill_we(fill_we), .fill_word(fill_word),
        .fill_adr(fill_adr), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr)
    );

    icache #(.LINE_WORDS(LINE_WORDS), .NUM_SETS(NUM_SETS)) u_icache (
        .clk(clk), .rst_n(rst_n), .pc(pc_q), .fill_we(fill_we), .fill_adr(fill_adr),
        .fill_word(fill_word), .fill_data(wb_dat_i), .hit(hit), .rd_instr(rd_instr)
    );

    next_pc u_next_pc (
        .pc(pc_q), .instr(rd_instr),
        .pred_pc(pred_pc), .is_br(is_br), .pred_taken(pred_taken)
    );

    // Target field carries the predicted next PC
    inst_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk(clk), .rst_n(rst_n), .push(fifo_push), .flush(fifo_flush),
        .in_instr(rd_instr), .in_pc(pc_q), .in_is_br(is_br), .in_taken(pred_taken),
        .in_target(pred_pc), .out_ready(instr_ready), .enq_ready(enq_ready),
        .out_valid(fifo_valid), .out_instr(instr_data), .out_pc(instr_pc),
        .out_is_br(instr_is_br), .out_taken(instr_pred_taken),
        .out_target(instr_pred_target)
    );

    assign instr_valid = fifo_valid & ~recovery_valid;  // Nothing transfers while flushing

endmodule

// ==== inst_fifo.sv ====
// Circular instruction queue toward dispatch with valid/ready on both sides and a flush
`timescale 1ns/1ps

module inst_fifo import ifu_pkg::*; #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   push,
    input  logic   flush,
    input  instr_t in_instr,
    input  addr_t  in_pc,
    input  logic   in_is_br,
    input  logic   in_taken,
    input  addr_t  in_target,
    input  logic   out_ready,
    output logic   enq_ready,
    output logic   out_valid,
    output instr_t out_instr,
    output addr_t  out_pc,
    output logic   out_is_br,
    output logic   out_taken,
    output addr_t  out_target
);
    localparam int PTR_W = $clog2(FIFO_DEPTH);

    // Entry fields in parallel arrays
    instr_t instr_mem  [FIFO_DEPTH];
    addr_t  pc_mem     [FIFO_DEPTH];
    logic   is_br_mem  [FIFO_DEPTH];
    logic   taken_mem  [FIFO_DEPTH];
    addr_t  target_mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;      // One extra bit for full
    logic             do_push;
    logic             do_pop;

    assign enq_ready = (count_q != (PTR_W + 1)'(FIFO_DEPTH));
    assign out_valid = (count_q != '0);
    assign do_push   = push & enq_ready;
    assign do_pop    = out_valid & out_ready;

    always_ff @(posedge clk) begin
        if (do_push && !flush) begin
            instr_mem[wr_ptr_q]  <= in_instr;
            pc_mem[wr_ptr_q]     <= in_pc;
            is_br_mem[wr_ptr_q]  <= in_is_br;
            taken_mem[wr_ptr_q]  <= in_taken;
            target_mem[wr_ptr_q] <= in_target;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush) begin       // Beats any same-cycle push or pop
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + (PTR_W + 1)'(do_push) - (PTR_W + 1)'(do_pop);
        end
    end

    // Head entry, holds while not popped
    assign out_instr  = instr_mem[rd_ptr_q];
    assign out_pc     = pc_mem[rd_ptr_q];
    assign out_is_br  = is_br_mem[rd_ptr_q];
    assign out_taken  = taken_mem[rd_ptr_q];
    assign out_target = target_mem[rd_ptr_q];

endmodule

// ==== next_pc.sv ====
// Predecoder forming the predicted next PC from jumps and backward conditional branches
`timescale 1ns/1ps

module next_pc import ifu_pkg::*; (
    input  addr_t  pc,
    input  instr_t instr,
    output addr_t  pred_pc,
    output logic   is_br,       // Control transfer, jump or conditional branch
    output logic   pred_taken
);
    opcode_t opcode;
    logic    is_jal;
    logic    is_cond;
    addr_t   j_off;             // Sign-extended J-type offset
    addr_t   b_off;             // Sign-extended B-type offset
    addr_t   seq_pc;
    addr_t   br_target;

    assign opcode  = instr[OPC_WIDTH-1:0];
    assign is_jal  = (opcode == OPC_JAL);
    assign is_cond = (opcode == OPC_BRANCH);

    // imm[20|10:1|11|19:12]
    assign j_off = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    // imm[12|10:5] and imm[4:1|11]
    assign b_off = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

    assign seq_pc    = pc + addr_t'(4);
    assign br_target = pc + (is_jal ? j_off : b_off);

    // Static prediction
    always_comb begin
        pred_taken = 1'b0;
        if (is_jal) begin
            pred_taken = 1'b1;              // Jumps always redirect
        end else if (is_cond) begin
            pred_taken = instr[31];         // Backward taken, forward not
        end
    end

    assign is_br   = is_jal | is_cond;
    assign pred_pc = pred_taken ? br_target : seq_pc;

endmodule

// ==== icache.sv ====
// Direct-mapped instruction cache with combinational lookup and word-by-word line fill
`timescale 1ns/1ps

module icache import ifu_pkg::*; #(
    parameter int LINE_WORDS = 4,
    parameter int NUM_SETS   = 16
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  addr_t                         pc,
    input  logic                          fill_we,
    input  addr_t                         fill_adr,
    input  logic [$clog2(LINE_WORDS)-1:0] fill_word,
    input  instr_t                        fill_data,
    output logic                          hit,
    output instr_t                        rd_instr
);
    localparam int OFF_W = $clog2(LINE_WORDS);          // Word offset in the line
    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = ADDR_WIDTH - IDX_W - OFF_W - 2;

    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [OFF_W-1:0] word_t;

    instr_t              data_mem [NUM_SETS][LINE_WORDS];
    tag_t                tag_mem  [NUM_SETS];
    logic [NUM_SETS-1:0] valid_q;

    // Lookup fields
    tag_t  rd_tag;
    idx_t  rd_idx;
    word_t rd_word;

    // Fill fields
    tag_t  wr_tag;
    idx_t  wr_idx;
    logic  wr_last;

    assign rd_word = pc[OFF_W+1:2];                     // Byte offset bits 1:0 ignored
    assign rd_idx  = pc[OFF_W+2 +: IDX_W];
    assign rd_tag  = pc[ADDR_WIDTH-1 -: TAG_W];

    assign wr_idx  = fill_adr[OFF_W+2 +: IDX_W];
    assign wr_tag  = fill_adr[ADDR_WIDTH-1 -: TAG_W];
    assign wr_last = (fill_word == word_t'(LINE_WORDS - 1));

    // Hit check and word select
    assign hit      = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);
    assign rd_instr = data_mem[rd_idx][rd_word];

    // Data and tag arrays
    always_ff @(posedge clk) begin
        if (fill_we) begin
            data_mem[wr_idx][fill_word] <= fill_data;
            if (wr_last) begin
                tag_mem[wr_idx] <= wr_tag;              // Tag with the final beat
            end
        end
    end

    // Valid bits, whole line valid only after its last word lands
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (fill_we && wr_last) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

endmodule

// ==== fetch_ctrl.sv ====
// Fetch control FSM deciding push, PC hold, Wishbone line refill and recovery flush
`timescale 1ns/1ps

module fetch_ctrl import ifu_pkg::*; #(
    parameter int LINE_WORDS = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          hit,            // Lookup result at current PC
    input  logic                          enq_ready,      // FIFO has room
    input  logic                          recovery_valid,
    input  addr_t                         pc,
    input  logic                          wb_ack,
    output logic                          pc_hold,
    output logic                          pc_redirect,
    output logic                          fifo_push,
    output logic                          fifo_flush,
    output logic                          fill_we,
    output logic [$clog2(LINE_WORDS)-1:0] fill_word,
    output addr_t                         fill_adr,
    output logic                          wb_cyc,
    output logic                          wb_stb,
    output addr_t                         wb_adr
);
    localparam int OFF_W = $clog2(LINE_WORDS);

    fetch_state_t     state_q;
    fetch_state_t     state_d;
    logic [OFF_W-1:0] beat_q;       // Word of the line on the bus
    addr_t            line_base_q;  // Line-aligned miss address
    logic             cyc_q;        // Classic cycle open
    logic             beat_done;
    logic             last_beat;
    logic             start_fill;

    assign beat_done  = cyc_q & wb_ack;
    assign last_beat  = (beat_q == OFF_W'(LINE_WORDS - 1));
    assign start_fill = (state_q == FETCH) && (state_d == REFILL);

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            FETCH: begin
                if (!hit && !recovery_valid) begin  // Miss on a PC that is about to change is dropped
                    state_d = REFILL;
                end
            end
            REFILL: begin
                if (beat_done && last_beat) begin
                    state_d = REFILL_WAIT;
                end
            end
            default: state_d = FETCH;               // REFILL_WAIT lasts one cycle
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= FETCH;
            cyc_q   <= 1'b0;
            beat_q  <= '0;
        end else begin
            state_q <= state_d;
            if (start_fill) begin
                cyc_q  <= 1'b1;                     // First beat opens with the state change
                beat_q <= '0;
            end else if (state_q == REFILL) begin
                if (beat_done) begin
                    cyc_q  <= 1'b0;                 // One idle cycle between beats
                    beat_q <= last_beat ? '0 : beat_q + 1'b1;
                end else if (!cyc_q) begin
                    cyc_q <= 1'b1;                  // Next beat after the gap
                end
            end
        end
    end

    // Line base captured at the miss
    always_ff @(posedge clk) begin
        if (start_fill) begin
            line_base_q <= {pc[ADDR_WIDTH-1:OFF_W+2], {(OFF_W + 2){1'b0}}};
        end
    end

    assign fifo_push   = (state_q == FETCH) & hit & enq_ready & ~recovery_valid;
    assign pc_hold     = (state_q != FETCH) | ~hit | ~enq_ready;  // Recovery wins in the PC mux
    assign pc_redirect = recovery_valid;
    assign fifo_flush  = recovery_valid;    // Drop everything fetched down the old path

    assign wb_cyc    = cyc_q;
    assign wb_stb    = cyc_q;               // Single classic cycles, strobe tracks cycle
    assign wb_adr    = line_base_q + addr_t'({beat_q, 2'b00});
    assign fill_we   = (state_q == REFILL) & beat_done;
    assign fill_word = beat_q;
    assign fill_adr  = line_base_q;

endmodule

// ==== ifu_pkg.sv ====
// IFU package with widths, word typedefs, predecode opcodes and fetch control states
package ifu_pkg;

    // Byte address and instruction widths
    localparam int ADDR_WIDTH  = 32;
    localparam int INSTR_WIDTH = 32;
    localparam int OPC_WIDTH   = 7;   // Major opcode field, bits 6:0

    // Byte address or PC
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // Raw instruction word
    typedef logic [INSTR_WIDTH-1:0] instr_t;

    // Major opcode of an instruction
    typedef logic [OPC_WIDTH-1:0] opcode_t;

    // Unconditional jump, J-type offset in bits 31:12
    localparam opcode_t OPC_JAL    = 7'b110_1111;

    // Conditional branch, B-type offset split over 31, 30:25, 11:8 and 7
    localparam opcode_t OPC_BRANCH = 7'b110_0011;

    // Fetch control states
    //   FETCH       lookup and push, one instruction per cycle on a hit
    //   REFILL      line fill, one Wishbone classic cycle per word
    //   REFILL_WAIT settle cycle after the line is marked valid
    typedef enum logic [1:0] {
        FETCH       = 2'd0,
        REFILL      = 2'd1,
        REFILL_WAIT = 2'd2
    } fetch_state_t;

endpackage
